//--- hw/mni_wrfill_params.svh
// Width, depth, packet layout and opcode bit macros shared by the MNI write/fill RTL
`ifndef MNI_WRFILL_PARAMS_SVH
`define MNI_WRFILL_PARAMS_SVH

// ==========================================================================
// Data path widths
// ==========================================================================
`define MNI_HW_W          16
`define MNI_WORD_W        32
`define MNI_BUF_AW        6

// ==========================================================================
// Packet layout, in halfwords from the opcode
// ==========================================================================
`define MNI_OFS_ADR_HI    1
`define MNI_OFS_ADR_LO    2
`define MNI_OFS_DATA0     3

// Whole packet lengths for one word and for a 16-word line
`define MNI_LEN_WORD      5
`define MNI_LEN_LINE      35

// ==========================================================================
// Opcode fields
// ==========================================================================
`define MNI_OP_NOFILL_BIT 10
`define MNI_OP_CLEAN_BIT  12
`define MNI_OP_FAULT_BIT  13
// Size field in bits 1..0, anything else is a line
`define MNI_OP_SIZE_WORD  2'b10

`endif

//--- hw/mni_wrfill_pkg.sv
// Types shared by the MNI write/fill blocks, referenced by scoped name
`default_nettype none

package mni_wrfill_pkg;

  // Sequencer states
  typedef enum logic [3:0] {
    Idle,
    BufOpcode,
    BufAdrHigh,
    BufAdrLow,
    BufInitHigh,
    BufInitLow,
    BufLineData,
    MissAdrHigh,
    MissAdrLow,
    MissDataHigh,
    MissDataLow,
    ClrBusy
  } seq_state_e;

  // Where a halfword load into the request registers comes from
  typedef enum logic [1:0] {
    SrcNone,
    SrcBuf,
    SrcMiss
  } req_src_e;

endpackage

`default_nettype wire

//--- hw/pkt_rx_buffer.sv
// Receive buffer that stores incoming packet halfwords for the write/fill sequencer
`timescale 1ns/1ns
`default_nettype none
`include "mni_wrfill_params.svh"

module pkt_rx_buffer (
  input  logic                   clk_ni,
  input  logic                   rst_ni,
  input  logic                   i_in_valid,
  input  logic [`MNI_HW_W-1:0]   i_in_data,
  input  logic                   i_clr_busy,
  input  logic [`MNI_BUF_AW-1:0] i_rd_adr,
  output logic [`MNI_HW_W-1:0]   o_rd_data,
  output logic                   o_in_busy,
  output logic                   o_busy
);

  logic [`MNI_HW_W-1:0]   mem [0:(1 << `MNI_BUF_AW)-1];
  logic [`MNI_BUF_AW-1:0] wr_cnt_d;
  logic [`MNI_BUF_AW-1:0] wr_cnt_q;
  logic                   busy_d;
  logic                   busy_q;

  // ==========================================================================
  // Write side
  // ==========================================================================

  // A new word always wins over the clear strobe
  assign busy_d = i_in_valid ? 1'b1 :
                  i_clr_busy ? 1'b0 :
                               busy_q;

  // Count restarts whenever no packet is held
  assign wr_cnt_d = !busy_d    ? '0 :
                    i_in_valid ? wr_cnt_q + 1'b1 :
                                 wr_cnt_q;

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      busy_q   <= 1'b0;
      wr_cnt_q <= '0;
    end else begin
      busy_q   <= busy_d;
      wr_cnt_q <= wr_cnt_d;
    end
  end

  always_ff @(posedge clk_ni) begin
    if (i_in_valid) begin
      mem[wr_cnt_q] <= i_in_data;
    end
  end

  // ==========================================================================
  // Read side and status
  // ==========================================================================
  assign o_rd_data = mem[i_rd_adr];
  assign o_in_busy = busy_q;
  assign o_busy    = busy_q;

endmodule

`default_nettype wire

//--- hw/wrfill_sequencer.sv
// Write/fill FSM that decodes buffered packets and misses and steers the request loads
`timescale 1ns/1ns
`default_nettype none
`include "mni_wrfill_params.svh"

module wrfill_sequencer (
  input  logic                     clk_ni,
  input  logic                     rst_ni,
  input  logic                     i_busy,
  input  logic [`MNI_HW_W-1:0]     i_rd_data,
  input  logic                     i_miss_valid,
  input  logic                     i_stall,
  output logic [`MNI_BUF_AW-1:0]   o_rd_adr,
  output logic                     o_clr_busy,
  output logic                     o_miss_stall,
  output mni_wrfill_pkg::req_src_e o_adr_hi_src,
  output mni_wrfill_pkg::req_src_e o_adr_lo_src,
  output mni_wrfill_pkg::req_src_e o_data_hi_src,
  output mni_wrfill_pkg::req_src_e o_data_lo_src,
  output logic                     o_issue_fill,
  output logic                     o_issue_write,
  output logic                     o_fault,
  output logic                     o_dirty,
  output logic                     o_line
);

  mni_wrfill_pkg::seq_state_e state_d;
  mni_wrfill_pkg::seq_state_e state_q;

  logic [`MNI_BUF_AW-1:0] send_cnt_d;
  logic [`MNI_BUF_AW-1:0] send_cnt_q;
  logic                   send_end;
  logic                   fill_q;
  logic                   dirty_q;
  logic                   fault_q;
  logic                   line_q;

  // Last halfword of a line packet
  assign send_end = (send_cnt_q == `MNI_BUF_AW'(`MNI_LEN_LINE - 1));

  // ==========================================================================
  // FSM
  // ==========================================================================
  always_comb begin
    state_d = state_q;
    case (state_q)
      // Miss is served ahead of a buffered packet
      mni_wrfill_pkg::Idle: begin
        if (i_miss_valid)
          state_d = mni_wrfill_pkg::MissAdrHigh;
        else if (i_busy)
          state_d = mni_wrfill_pkg::BufOpcode;
      end
      mni_wrfill_pkg::BufOpcode:    state_d = mni_wrfill_pkg::BufAdrHigh;
      mni_wrfill_pkg::BufAdrHigh:   state_d = mni_wrfill_pkg::BufAdrLow;
      mni_wrfill_pkg::BufAdrLow:    state_d = mni_wrfill_pkg::BufInitHigh;
      mni_wrfill_pkg::BufInitHigh:  state_d = mni_wrfill_pkg::BufInitLow;
      mni_wrfill_pkg::BufInitLow: begin
        if (!i_stall)
          state_d = line_q ? mni_wrfill_pkg::BufLineData : mni_wrfill_pkg::ClrBusy;
      end
      mni_wrfill_pkg::BufLineData: begin
        if (send_end)
          state_d = mni_wrfill_pkg::ClrBusy;
      end
      mni_wrfill_pkg::MissAdrHigh:  state_d = mni_wrfill_pkg::MissAdrLow;
      mni_wrfill_pkg::MissAdrLow:   state_d = mni_wrfill_pkg::MissDataHigh;
      mni_wrfill_pkg::MissDataHigh: state_d = mni_wrfill_pkg::MissDataLow;
      mni_wrfill_pkg::MissDataLow: begin
        if (!i_stall)
          state_d = mni_wrfill_pkg::Idle;
      end
      default: state_d = mni_wrfill_pkg::Idle;
    endcase
  end

  // Line data starts right after the first word of the packet
  assign send_cnt_d = (state_q == mni_wrfill_pkg::BufInitLow)  ? `MNI_BUF_AW'(`MNI_LEN_WORD) :
                      (state_q == mni_wrfill_pkg::BufLineData) ? send_cnt_q + 1'b1 :
                                                                 send_cnt_q;

  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      state_q    <= mni_wrfill_pkg::Idle;
      send_cnt_q <= '0;
      fill_q     <= 1'b0;
      dirty_q    <= 1'b0;
      fault_q    <= 1'b0;
      line_q     <= 1'b0;
    end else begin
      state_q    <= state_d;
      send_cnt_q <= send_cnt_d;
      if (state_q == mni_wrfill_pkg::BufOpcode) begin
        fill_q  <= !i_rd_data[`MNI_OP_NOFILL_BIT];
        dirty_q <= !i_rd_data[`MNI_OP_CLEAN_BIT];
        fault_q <= i_rd_data[`MNI_OP_FAULT_BIT];
        line_q  <= (i_rd_data[1:0] != `MNI_OP_SIZE_WORD);
      end else if (state_q == mni_wrfill_pkg::MissAdrHigh) begin
        // Miss is always a clean single-word fill
        fill_q  <= 1'b0;
        dirty_q <= 1'b0;
        fault_q <= 1'b0;
        line_q  <= 1'b0;
      end
    end
  end

  // ==========================================================================
  // Buffer reads and request loads
  // ==========================================================================
  always_comb begin
    case (state_q)
      mni_wrfill_pkg::BufAdrHigh:  o_rd_adr = `MNI_BUF_AW'(`MNI_OFS_ADR_HI);
      mni_wrfill_pkg::BufAdrLow:   o_rd_adr = `MNI_BUF_AW'(`MNI_OFS_ADR_LO);
      mni_wrfill_pkg::BufInitHigh: o_rd_adr = `MNI_BUF_AW'(`MNI_OFS_DATA0);
      mni_wrfill_pkg::BufInitLow:  o_rd_adr = `MNI_BUF_AW'(`MNI_OFS_DATA0 + 1);
      mni_wrfill_pkg::BufLineData: o_rd_adr = send_cnt_q;
      default:                     o_rd_adr = '0;
    endcase
  end

  always_comb begin
    o_adr_hi_src  = mni_wrfill_pkg::SrcNone;
    o_adr_lo_src  = mni_wrfill_pkg::SrcNone;
    o_data_hi_src = mni_wrfill_pkg::SrcNone;
    o_data_lo_src = mni_wrfill_pkg::SrcNone;
    case (state_q)
      mni_wrfill_pkg::BufAdrHigh:   o_adr_hi_src  = mni_wrfill_pkg::SrcBuf;
      mni_wrfill_pkg::BufAdrLow:    o_adr_lo_src  = mni_wrfill_pkg::SrcBuf;
      mni_wrfill_pkg::BufInitHigh:  o_data_hi_src = mni_wrfill_pkg::SrcBuf;
      mni_wrfill_pkg::BufInitLow:   o_data_lo_src = mni_wrfill_pkg::SrcBuf;
      mni_wrfill_pkg::MissAdrHigh:  o_adr_hi_src  = mni_wrfill_pkg::SrcMiss;
      mni_wrfill_pkg::MissAdrLow:   o_adr_lo_src  = mni_wrfill_pkg::SrcMiss;
      mni_wrfill_pkg::MissDataHigh: o_data_hi_src = mni_wrfill_pkg::SrcMiss;
      mni_wrfill_pkg::MissDataLow:  o_data_lo_src = mni_wrfill_pkg::SrcMiss;
      // Odd offsets are high halves
      mni_wrfill_pkg::BufLineData: begin
        if (send_cnt_q[0])
          o_data_hi_src = mni_wrfill_pkg::SrcBuf;
        else
          o_data_lo_src = mni_wrfill_pkg::SrcBuf;
      end
      default: ;
    endcase
  end

  // ==========================================================================
  // Outputs
  // ==========================================================================
  assign o_issue_fill  = ((state_q == mni_wrfill_pkg::BufInitLow) && fill_q) ||
                         (state_q == mni_wrfill_pkg::MissDataLow);
  assign o_issue_write = (state_q == mni_wrfill_pkg::BufInitLow) && !fill_q;
  assign o_clr_busy    = (state_q == mni_wrfill_pkg::ClrBusy);

  // Last miss halfword is taken only once the fill is accepted
  assign o_miss_stall = !((state_q == mni_wrfill_pkg::MissAdrHigh) ||
                          (state_q == mni_wrfill_pkg::MissAdrLow) ||
                          (state_q == mni_wrfill_pkg::MissDataHigh) ||
                          ((state_q == mni_wrfill_pkg::MissDataLow) && !i_stall));

  assign o_fault = fault_q;
  assign o_dirty = dirty_q;
  assign o_line  = line_q;

endmodule

`default_nettype wire

//--- hw/l2c_req_builder.sv
// Request register block that assembles L2 fill and write requests from halfword loads
`timescale 1ns/1ns
`default_nettype none
`include "mni_wrfill_params.svh"

module l2c_req_builder (
  input  logic                     clk_ni,
  input  logic                     rst_ni,
  input  logic [`MNI_HW_W-1:0]     i_rd_data,
  input  logic [`MNI_HW_W-1:0]     i_miss_data,
  input  mni_wrfill_pkg::req_src_e i_adr_hi_src,
  input  mni_wrfill_pkg::req_src_e i_adr_lo_src,
  input  mni_wrfill_pkg::req_src_e i_data_hi_src,
  input  mni_wrfill_pkg::req_src_e i_data_lo_src,
  input  logic                     i_issue_fill,
  input  logic                     i_issue_write,
  input  logic                     i_fault,
  input  logic                     i_dirty,
  input  logic                     i_line,
  input  logic                     i_l2c_fill_stall,
  input  logic                     i_l2c_write_stall,
  output logic                     o_stall,
  output logic                     o_l2c_fill_valid,
  output logic                     o_l2c_write_valid,
  output logic [`MNI_WORD_W-1:0]   o_l2c_adr,
  output logic [`MNI_WORD_W-1:0]   o_l2c_data,
  output logic [3:0]               o_l2c_fill_len,
  output logic                     o_l2c_fill_fault,
  output logic                     o_l2c_write_dirty
);

  logic [`MNI_WORD_W-1:0] adr_q;
  logic [`MNI_WORD_W-1:0] data_q;
  logic                   fill_valid_q;
  logic                   write_valid_q;

  // Next value of one halfword register
  function automatic logic [`MNI_HW_W-1:0] pick_half(
    input mni_wrfill_pkg::req_src_e src,
    input logic [`MNI_HW_W-1:0]     cur
  );
    case (src)
      mni_wrfill_pkg::SrcBuf:  pick_half = i_rd_data;
      mni_wrfill_pkg::SrcMiss: pick_half = i_miss_data;
      default:                 pick_half = cur;
    endcase
  endfunction

  // ==========================================================================
  // Address and data
  // ==========================================================================
  always_ff @(posedge clk_ni) begin
    adr_q[`MNI_WORD_W-1:`MNI_HW_W]  <= pick_half(i_adr_hi_src, adr_q[`MNI_WORD_W-1:`MNI_HW_W]);
    adr_q[`MNI_HW_W-1:0]            <= pick_half(i_adr_lo_src, adr_q[`MNI_HW_W-1:0]);
    data_q[`MNI_WORD_W-1:`MNI_HW_W] <= pick_half(i_data_hi_src, data_q[`MNI_WORD_W-1:`MNI_HW_W]);
    data_q[`MNI_HW_W-1:0]           <= pick_half(i_data_lo_src, data_q[`MNI_HW_W-1:0]);
  end

  // ==========================================================================
  // Request strobes
  // ==========================================================================
  always_ff @(posedge clk_ni) begin
    if (rst_ni) begin
      fill_valid_q  <= 1'b0;
      write_valid_q <= 1'b0;
    end else begin
      fill_valid_q  <= i_issue_fill;
      write_valid_q <= i_issue_write;
    end
  end

  // Back-pressure follows the request being issued
  assign o_stall = (i_issue_fill && i_l2c_fill_stall) ||
                   (i_issue_write && i_l2c_write_stall);

  assign o_l2c_fill_valid  = fill_valid_q;
  assign o_l2c_write_valid = write_valid_q;
  assign o_l2c_adr         = adr_q;
  assign o_l2c_data        = data_q;
  assign o_l2c_fill_len    = {4{i_line}};
  assign o_l2c_fill_fault  = i_fault;
  assign o_l2c_write_dirty = i_dirty;

endmodule

`default_nettype wire

//--- hw/mni_wrfill_top.sv
// Top level of the MNI write/fill path from packet and miss ports to the L2 cache
`timescale 1ns/1ns
`default_nettype none
`include "mni_wrfill_params.svh"

module mni_wrfill_top (
  input  logic                   clk_ni,
  input  logic                   rst_ni,
  // In port
  input  logic                   i_in_valid,
  input  logic [`MNI_HW_W-1:0]   i_in_data,
  output logic                   o_in_busy,
  // Miss port
  input  logic                   i_miss_valid,
  input  logic [`MNI_HW_W-1:0]   i_miss_data,
  output logic                   o_miss_stall,
  // L2 fill request
  output logic                   o_l2c_fill_valid,
  output logic [`MNI_WORD_W-1:0] o_l2c_fill_adr,
  output logic [3:0]             o_l2c_fill_len,
  output logic                   o_l2c_fill_fault,
  input  logic                   i_l2c_fill_stall,
  // L2 write request
  output logic                   o_l2c_write_valid,
  output logic [`MNI_WORD_W-1:0] o_l2c_write_adr,
  output logic                   o_l2c_write_dirty,
  input  logic                   i_l2c_write_stall,
  // Shared data
  output logic [`MNI_WORD_W-1:0] o_l2c_data
);

  logic                     rx_busy;
  logic [`MNI_HW_W-1:0]     rd_data;
  logic [`MNI_BUF_AW-1:0]   rd_adr;
  logic                     clr_busy;
  logic                     stall;
  mni_wrfill_pkg::req_src_e adr_hi_src;
  mni_wrfill_pkg::req_src_e adr_lo_src;
  mni_wrfill_pkg::req_src_e data_hi_src;
  mni_wrfill_pkg::req_src_e data_lo_src;
  logic                     issue_fill;
  logic                     issue_write;
  logic                     fault;
  logic                     dirty;
  logic                     line;
  logic [`MNI_WORD_W-1:0]   l2c_adr;

  pkt_rx_buffer pkt_rx_buffer_i (
    .clk_ni     (clk_ni),
    .rst_ni     (rst_ni),
    .i_in_valid (i_in_valid),
    .i_in_data  (i_in_data),
    .i_clr_busy (clr_busy),
    .i_rd_adr   (rd_adr),
    .o_rd_data  (rd_data),
    .o_in_busy  (o_in_busy),
    .o_busy     (rx_busy)
  );

  wrfill_sequencer wrfill_sequencer_i (
    .clk_ni        (clk_ni),
    .rst_ni        (rst_ni),
    .i_busy        (rx_busy),
    .i_rd_data     (rd_data),
    .i_miss_valid  (i_miss_valid),
    .i_stall       (stall),
    .o_rd_adr      (rd_adr),
    .o_clr_busy    (clr_busy),
    .o_miss_stall  (o_miss_stall),
    .o_adr_hi_src  (adr_hi_src),
    .o_adr_lo_src  (adr_lo_src),
    .o_data_hi_src (data_hi_src),
    .o_data_lo_src (data_lo_src),
    .o_issue_fill  (issue_fill),
    .o_issue_write (issue_write),
    .o_fault       (fault),
    .o_dirty       (dirty),
    .o_line        (line)
  );

  l2c_req_builder l2c_req_builder_i (
    .clk_ni            (clk_ni),
    .rst_ni            (rst_ni),
    .i_rd_data         (rd_data),
    .i_miss_data       (i_miss_data),
    .i_adr_hi_src      (adr_hi_src),
    .i_adr_lo_src      (adr_lo_src),
    .i_data_hi_src     (data_hi_src),
    .i_data_lo_src     (data_lo_src),
    .i_issue_fill      (issue_fill),
    .i_issue_write     (issue_write),
    .i_fault           (fault),
    .i_dirty           (dirty),
    .i_line            (line),
    .i_l2c_fill_stall  (i_l2c_fill_stall),
    .i_l2c_write_stall (i_l2c_write_stall),
    .o_stall           (stall),
    .o_l2c_fill_valid  (o_l2c_fill_valid),
    .o_l2c_write_valid (o_l2c_write_valid),
    .o_l2c_adr         (l2c_adr),
    .o_l2c_data        (o_l2c_data),
    .o_l2c_fill_len    (o_l2c_fill_len),
    .o_l2c_fill_fault  (o_l2c_fill_fault),
    .o_l2c_write_dirty (o_l2c_write_dirty)
  );

  // One address register serves both request kinds
  assign o_l2c_fill_adr  = l2c_adr;
  assign o_l2c_write_adr = l2c_adr;

endmodule

`default_nettype wire

//--- verif/tb_mni_wrfill_tasks.svh
// Driver, check and scenario tasks included into the body of the write/fill testbench top
`ifndef TB_MNI_WRFILL_TASKS_SVH
`define TB_MNI_WRFILL_TASKS_SVH

// Next pseudo-random value
function automatic logic [31:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
  if (got !== exp) begin
    $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("TEST FAILED");
    $fatal(1);
  end
endtask

// Opcode with the decoded fields set and the ignored bits random
function automatic logic [15:0] make_opcode(input logic fill, input logic dirty,
                                            input logic fault, input logic line);
  logic [31:0] r;
  logic [15:0] op;
  r  = lcg_next();
  op = r[15:0];
  op[`MNI_OP_NOFILL_BIT] = !fill;
  op[`MNI_OP_CLEAN_BIT]  = !dirty;
  op[`MNI_OP_FAULT_BIT]  = fault;
  op[1:0] = `MNI_OP_SIZE_WORD;
  if (line)
    op[1:0] = (r[17:16] == `MNI_OP_SIZE_WORD) ? 2'b01 : r[17:16];
  return op;
endfunction

task automatic make_packet(input logic fill, input logic dirty, input logic fault,
                           input logic line, output logic [31:0] adr);
  logic [31:0] word;
  int          n;
  pkt_buf[0] = make_opcode(fill, dirty, fault, line);
  adr        = lcg_next();
  pkt_buf[1] = adr[31:16];
  pkt_buf[2] = adr[15:0];
  n = line ? 16 : 1;
  // High half of each word goes first
  for (int k = 0; k < n; k++) begin
    word             = lcg_next();
    exp_words[k]     = word;
    pkt_buf[3 + 2*k] = word[31:16];
    pkt_buf[4 + 2*k] = word[15:0];
  end
  pkt_len = line ? `MNI_LEN_LINE : `MNI_LEN_WORD;
endtask

task automatic send_packet();
  for (int i = 0; i < pkt_len; i++) begin
    @(negedge clk_ni);
    i_in_valid = 1'b1;
    i_in_data  = pkt_buf[i];
  end
  @(negedge clk_ni);
  i_in_valid = 1'b0;
endtask

// Halfword is taken at the next rising edge when the stall is low
task automatic feed_miss(input logic [31:0] adr, input logic [31:0] data);
  logic [15:0] hw [0:3];
  int          idx;
  hw[0] = adr[31:16];
  hw[1] = adr[15:0];
  hw[2] = data[31:16];
  hw[3] = data[15:0];
  idx   = 0;
  while (idx < 4) begin
    @(negedge clk_ni);
    i_miss_valid = 1'b1;
    i_miss_data  = hw[idx];
    if (!o_miss_stall)
      idx++;
  end
  @(negedge clk_ni);
  i_miss_valid = 1'b0;
endtask

task automatic await_request(input logic exp_fill);
  while (!(o_l2c_fill_valid || o_l2c_write_valid)) begin
    @(negedge clk_ni);
  end
  check_value("fill valid", o_l2c_fill_valid, exp_fill);
  check_value("write valid", o_l2c_write_valid, !exp_fill);
endtask

task automatic check_fields(input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] len, input logic fault, input logic dirty);
  check_value("fill address", o_l2c_fill_adr, adr);
  check_value("write address", o_l2c_write_adr, adr);
  check_value("request data", o_l2c_data, data);
  check_value("fill length", o_l2c_fill_len, len);
  check_value("fill fault", o_l2c_fill_fault, fault);
  check_value("write dirty", o_l2c_write_dirty, dirty);
endtask

task automatic expect_no_request();
  @(negedge clk_ni);
  check_value("fill valid after request", o_l2c_fill_valid, 1'b0);
  check_value("write valid after request", o_l2c_write_valid, 1'b0);
endtask

task automatic wait_rx_idle();
  while (o_in_busy) begin
    @(negedge clk_ni);
  end
  @(negedge clk_ni);
endtask

// ==========================================================================
// Scenarios
// ==========================================================================
task automatic reset_outputs_idle();
  check_value("fill valid in reset", o_l2c_fill_valid, 1'b0);
  check_value("write valid in reset", o_l2c_write_valid, 1'b0);
  check_value("in busy in reset", o_in_busy, 1'b0);
  check_value("miss stall in reset", o_miss_stall, 1'b1);
endtask

task automatic word_fill_request();
  logic [31:0] adr;
  logic [31:0] r;
  r = lcg_next();
  make_packet(1'b1, r[5], r[4], 1'b0, adr);
  send_packet();
  await_request(1'b1);
  check_fields(adr, exp_words[0], 4'h0, r[4], r[5]);
  expect_no_request();
  wait_rx_idle();
endtask

task automatic stalled_word_write(input int n_stall);
  logic [31:0] adr;
  int          cnt;
  make_packet(1'b0, 1'b1, 1'b0, 1'b0, adr);
  i_l2c_write_stall = 1'b1;
  send_packet();
  await_request(1'b0);
  check_fields(adr, exp_words[0], 4'h0, 1'b0, 1'b1);
  cnt = 1;
  while (cnt < n_stall) begin
    @(negedge clk_ni);
    check_value("write valid while stalled", o_l2c_write_valid, 1'b1);
    check_value("in busy while stalled", o_in_busy, 1'b1);
    cnt++;
  end
  i_l2c_write_stall = 1'b0;
  // Request is accepted in the cycle after the release
  @(negedge clk_ni);
  check_value("write valid at release", o_l2c_write_valid, 1'b1);
  check_value("in busy at release", o_in_busy, 1'b1);
  expect_no_request();
  wait_rx_idle();
endtask

task automatic line_write_burst();
  logic [31:0] adr;
  make_packet(1'b0, 1'b1, 1'b0, 1'b1, adr);
  fork
    send_packet();
    begin
      await_request(1'b0);
      check_fields(adr, exp_words[0], 4'hf, 1'b0, 1'b1);
      // Word k is complete 2k cycles after the first valid cycle
      for (int k = 1; k < 16; k++) begin
        repeat (2) @(negedge clk_ni);
        check_value($sformatf("line data word %0d", k), o_l2c_data, exp_words[k]);
        check_value("write valid during line", o_l2c_write_valid, 1'b0);
      end
    end
  join
  wait_rx_idle();
endtask

task automatic miss_fill_request();
  logic [31:0] adr;
  logic [31:0] data;
  adr  = lcg_next();
  data = lcg_next();
  feed_miss(adr, data);
  await_request(1'b1);
  check_fields(adr, data, 4'h0, 1'b0, 1'b0);
  expect_no_request();
  check_value("miss stall when idle", o_miss_stall, 1'b1);
endtask

// Miss arrives one cycle after the packet start so both wait in Idle
task automatic miss_before_packet();
  logic [31:0] pkt_adr;
  logic [31:0] miss_adr;
  logic [31:0] miss_data;
  make_packet(1'b1, 1'b0, 1'b1, 1'b0, pkt_adr);
  miss_adr  = lcg_next();
  miss_data = lcg_next();
  fork
    send_packet();
    begin
      @(negedge clk_ni);
      feed_miss(miss_adr, miss_data);
      await_request(1'b1);
      check_fields(miss_adr, miss_data, 4'h0, 1'b0, 1'b0);
    end
  join
  expect_no_request();
  await_request(1'b1);
  check_fields(pkt_adr, exp_words[0], 4'h0, 1'b1, 1'b0);
  expect_no_request();
  wait_rx_idle();
endtask

`endif

//--- verif/tb_mni_wrfill.sv
// Testbench top for the MNI write/fill block, compiled with the tb.f file list
`timescale 1ns/1ns
`default_nettype none
`include "mni_wrfill_params.svh"

module tb_mni_wrfill;

  localparam int CLK_HALF   = 20;
  localparam int MAX_CYCLES = 4000;

  logic                   clk_ni;
  logic                   rst_ni;
  logic                   i_in_valid;
  logic [`MNI_HW_W-1:0]   i_in_data;
  logic                   o_in_busy;
  logic                   i_miss_valid;
  logic [`MNI_HW_W-1:0]   i_miss_data;
  logic                   o_miss_stall;
  logic                   o_l2c_fill_valid;
  logic [`MNI_WORD_W-1:0] o_l2c_fill_adr;
  logic [3:0]             o_l2c_fill_len;
  logic                   o_l2c_fill_fault;
  logic                   i_l2c_fill_stall;
  logic                   o_l2c_write_valid;
  logic [`MNI_WORD_W-1:0] o_l2c_write_adr;
  logic                   o_l2c_write_dirty;
  logic                   i_l2c_write_stall;
  logic [`MNI_WORD_W-1:0] o_l2c_data;

  // Packet being sent and the data words it carries
  logic [`MNI_HW_W-1:0]   pkt_buf [0:`MNI_LEN_LINE-1];
  logic [`MNI_WORD_W-1:0] exp_words [0:15];
  int                     pkt_len;
  logic [31:0]            lcg_state;
  int                     cycle_cnt = 0;

  mni_wrfill_top mni_wrfill_top_i (
    .clk_ni            (clk_ni),
    .rst_ni            (rst_ni),
    .i_in_valid        (i_in_valid),
    .i_in_data         (i_in_data),
    .o_in_busy         (o_in_busy),
    .i_miss_valid      (i_miss_valid),
    .i_miss_data       (i_miss_data),
    .o_miss_stall      (o_miss_stall),
    .o_l2c_fill_valid  (o_l2c_fill_valid),
    .o_l2c_fill_adr    (o_l2c_fill_adr),
    .o_l2c_fill_len    (o_l2c_fill_len),
    .o_l2c_fill_fault  (o_l2c_fill_fault),
    .i_l2c_fill_stall  (i_l2c_fill_stall),
    .o_l2c_write_valid (o_l2c_write_valid),
    .o_l2c_write_adr   (o_l2c_write_adr),
    .o_l2c_write_dirty (o_l2c_write_dirty),
    .i_l2c_write_stall (i_l2c_write_stall),
    .o_l2c_data        (o_l2c_data)
  );

  // ==========================================================================
  // Clock and watchdog
  // ==========================================================================
  initial clk_ni = 1'b0;
  always #CLK_HALF clk_ni = ~clk_ni;

  always @(posedge clk_ni) begin
    if (cycle_cnt < MAX_CYCLES) begin
      cycle_cnt <= cycle_cnt + 1;
    end else begin
      $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

  `include "tb_mni_wrfill_tasks.svh"

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    rst_ni            = 1'b1;
    i_in_valid        = 1'b0;
    i_in_data         = '0;
    i_miss_valid      = 1'b0;
    i_miss_data       = '0;
    i_l2c_fill_stall  = 1'b0;
    i_l2c_write_stall = 1'b0;
    lcg_state         = 32'h4272_c788;
    pkt_len           = 0;

    // Two rising edges in reset
    repeat (2) @(negedge clk_ni);
    rst_ni = 1'b0;

    reset_outputs_idle();
    word_fill_request();
    stalled_word_write(3);
    line_write_burst();
    miss_fill_request();
    miss_before_packet();

    repeat (2) @(negedge clk_ni);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
+incdir+verif
hw/mni_wrfill_pkg.sv
hw/pkt_rx_buffer.sv
hw/wrfill_sequencer.sv
hw/l2c_req_builder.sv
hw/mni_wrfill_top.sv
verif/tb_mni_wrfill.sv

//--- Bender.yml
package:
  name: mni_wrfill

sources:
  - include_dirs:
      - hw
    files:
      - hw/mni_wrfill_pkg.sv
      - hw/pkt_rx_buffer.sv
      - hw/wrfill_sequencer.sv
      - hw/l2c_req_builder.sv
      - hw/mni_wrfill_top.sv
  - target: simulation
    include_dirs:
      - hw
      - verif
    files:
      - verif/tb_mni_wrfill.sv
